//--- common/lpf_pkg.sv
package lpf_pkg;

	// Image geometry, the frame is square
	localparam int unsigned IMAGE_DIM = 16;
	localparam int unsigned COORD_W = (IMAGE_DIM > 1) ? $clog2(IMAGE_DIM) : 1;

	// Each pixel carries three 8-bit colour channels
	localparam int unsigned NUM_CHANNELS = 3;
	localparam int unsigned CHAN_W = 8;

	// Channel order inside a pixel and inside a window, red sits highest
	localparam int unsigned CH_RED = 2;
	localparam int unsigned CH_GREEN = 1;
	localparam int unsigned CH_BLUE = 0;

	// Only the 3x3 kernel exists
	localparam int unsigned KERNEL_DIM = 3;
	localparam int unsigned WIN_TAPS = KERNEL_DIM * KERNEL_DIM;
	localparam int unsigned CHAN_WIN_W = WIN_TAPS * CHAN_W;

	// Kernel weights 1, 2 and 4 expressed as left shifts, they sum to 16
	localparam int unsigned CORNER_SHIFT = 0;
	localparam int unsigned EDGE_SHIFT = 1;
	localparam int unsigned CENTRE_SHIFT = 2;

	// A sum of weight 16 moves into Q12.12 with a shift of 12 - 4
	localparam int unsigned SUM_TO_Q_SHIFT = 8;
	// A raw channel moves into Q12.12 with the full fraction shift
	localparam int unsigned PIX_TO_Q_SHIFT = 12;

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [NUM_CHANNELS*CHAN_W-1:0] pixel_t;
	typedef logic [CHAN_W-1:0] channel_t;
	// Row-major taps, the top-left tap is the lowest byte
	typedef logic [CHAN_WIN_W-1:0] chan_win_t;
	typedef logic [NUM_CHANNELS*CHAN_WIN_W-1:0] window_t;
	// 255 * 16 fits in 12 bits
	typedef logic [11:0] wsum_t;
	typedef logic [23:0] fixed_t;

	// Last row or column index, used by the border and end-of-frame tests
	localparam coord_t COORD_MAX = coord_t'(IMAGE_DIM - 1);

	typedef enum logic [1:0] {
		ws_idle,
		ws_stream,
		ws_flush
	} win_state_t;

endpackage

//--- window/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
	input logic clk,
	input logic rst_n,
	input logic shift_en,
	input lpf_pkg::pixel_t pix_in,
	output lpf_pkg::pixel_t row1_tap,
	output lpf_pkg::pixel_t row2_tap
);

	// Two delay lines of one image row each, the second fed by the end of the first
	lpf_pkg::pixel_t line1 [lpf_pkg::IMAGE_DIM];
	lpf_pkg::pixel_t line2 [lpf_pkg::IMAGE_DIM];

	// The oldest entry of each line is the pixel one or two rows above the
	// pixel currently on pix_in, so the taps need no extra register stage
	assign row1_tap = line1[lpf_pkg::IMAGE_DIM-1];
	assign row2_tap = line2[lpf_pkg::IMAGE_DIM-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// The upper rows of the first frame start out black
			for (int i = 0; i < lpf_pkg::IMAGE_DIM; i++) begin
				line1[i] <= '0;
				line2[i] <= '0;
			end
		end else if (shift_en) begin
			// Both lines move one position per beat, idle cycles hold them
			line1[0] <= pix_in;
			line2[0] <= line1[lpf_pkg::IMAGE_DIM-1];
			for (int i = 1; i < lpf_pkg::IMAGE_DIM; i++) begin
				line1[i] <= line1[i-1];
				line2[i] <= line2[i-1];
			end
		end
	end

endmodule

//--- window/window_gen.sv
`timescale 1ns/1ps

module window_gen (
	input logic clk,
	input logic rst_n,
	input logic pixel_valid,
	input logic soc_in,
	input logic eoc_in,
	input logic blur_en,
	input lpf_pkg::pixel_t pixel_in,
	output logic win_valid,
	output lpf_pkg::window_t win,
	output logic win_border,
	output logic win_first,
	output logic win_last
);

	lpf_pkg::win_state_t state;

	// A beat is a real pixel taken in or a flush beat made up here
	logic start_beat;
	logic beat;
	logic win_ready;
	lpf_pkg::pixel_t beat_pix;

	// Position of the next input pixel and of the centre of the next window
	lpf_pkg::coord_t in_row;
	lpf_pkg::coord_t in_col;
	lpf_pkg::coord_t ctr_row;
	lpf_pkg::coord_t ctr_col;
	logic ctr_last;
	logic ctr_on_border;

	// Mode of the current frame as taken on its first pixel
	logic blur_q;

	lpf_pkg::pixel_t row1_tap;
	lpf_pkg::pixel_t row2_tap;

	// Row 0 is the top of the window and column KERNEL_DIM-1 holds the newest pixel
	lpf_pkg::pixel_t win_pix [lpf_pkg::KERNEL_DIM][lpf_pkg::KERNEL_DIM];

	line_buffer line_buffer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.shift_en(beat),
		.pix_in(beat_pix),
		.row1_tap(row1_tap),
		.row2_tap(row2_tap)
	);

	// A frame is only picked up from idle when its first pixel is marked
	assign start_beat = (state == lpf_pkg::ws_idle) && pixel_valid && soc_in;

	always_comb begin
		beat = 1'b0;
		win_ready = 1'b0;
		case (state)
			lpf_pkg::ws_idle: begin
				beat = start_beat;
			end
			lpf_pkg::ws_stream: begin
				beat = pixel_valid;
				// The first window completes on the beat of input (1,1)
				win_ready = pixel_valid && (in_row != '0) &&
					!((in_row == lpf_pkg::coord_t'(1)) && (in_col == '0));
			end
			lpf_pkg::ws_flush: begin
				// Flush beats run back to back and each one finishes a window
				beat = 1'b1;
				win_ready = 1'b1;
			end
			default: begin
				beat = 1'b0;
			end
		endcase
	end

	// Flush beats push black pixels through the rows
	assign beat_pix = (state == lpf_pkg::ws_flush) ? '0 : pixel_in;

	assign ctr_last = (ctr_row == lpf_pkg::COORD_MAX) && (ctr_col == lpf_pkg::COORD_MAX);
	assign ctr_on_border = (ctr_row == '0) || (ctr_row == lpf_pkg::COORD_MAX) ||
		(ctr_col == '0) || (ctr_col == lpf_pkg::COORD_MAX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= lpf_pkg::ws_idle;
			in_row <= '0;
			in_col <= '0;
			ctr_row <= '0;
			ctr_col <= '0;
			blur_q <= 1'b0;
		end else begin
			case (state)
				lpf_pkg::ws_idle: begin
					if (start_beat) begin
						state <= eoc_in ? lpf_pkg::ws_flush : lpf_pkg::ws_stream;
					end
				end
				lpf_pkg::ws_stream: begin
					if (pixel_valid && eoc_in) begin
						state <= lpf_pkg::ws_flush;
					end
				end
				lpf_pkg::ws_flush: begin
					// The last flush beat carries the bottom-right centre
					if (ctr_last) begin
						state <= lpf_pkg::ws_idle;
					end
				end
				default: begin
					state <= lpf_pkg::ws_idle;
				end
			endcase

			// The start pixel sits at (0,0), so the next one is at (0,1)
			if (start_beat) begin
				blur_q <= blur_en;
				in_row <= '0;
				in_col <= lpf_pkg::coord_t'(1);
			end else if ((state == lpf_pkg::ws_stream) && pixel_valid) begin
				if (in_col == lpf_pkg::COORD_MAX) begin
					in_col <= '0;
					in_row <= in_row + 1'b1;
				end else begin
					in_col <= in_col + 1'b1;
				end
			end

			// Centre counters walk the output raster by one step per finished window
			if (start_beat) begin
				ctr_row <= '0;
				ctr_col <= '0;
			end else if (win_ready) begin
				if (ctr_col == lpf_pkg::COORD_MAX) begin
					ctr_col <= '0;
					ctr_row <= ctr_last ? '0 : ctr_row + 1'b1;
				end else begin
					ctr_col <= ctr_col + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_valid <= 1'b0;
			win_border <= 1'b0;
			win_first <= 1'b0;
			win_last <= 1'b0;
		end else begin
			win_valid <= win_ready;
			// Bypass frames pass every centre through as if it were a border pixel
			win_border <= ctr_on_border || !blur_q;
			win_first <= win_ready && (ctr_row == '0) && (ctr_col == '0);
			win_last <= win_ready && ctr_last;
		end
	end

	// Each beat moves every window row one column left and loads the new column
	always_ff @(posedge clk) begin
		if (beat) begin
			for (int r = 0; r < lpf_pkg::KERNEL_DIM; r++) begin
				for (int c = 0; c < lpf_pkg::KERNEL_DIM - 1; c++) begin
					win_pix[r][c] <= win_pix[r][c+1];
				end
			end
			win_pix[0][lpf_pkg::KERNEL_DIM-1] <= row2_tap;
			win_pix[1][lpf_pkg::KERNEL_DIM-1] <= row1_tap;
			win_pix[lpf_pkg::KERNEL_DIM-1][lpf_pkg::KERNEL_DIM-1] <= beat_pix;
		end
	end

	// Each pixel splits into its channels and channel g of a pixel goes to slice g
	always_comb begin
		for (int ch = 0; ch < lpf_pkg::NUM_CHANNELS; ch++) begin
			for (int r = 0; r < lpf_pkg::KERNEL_DIM; r++) begin
				for (int c = 0; c < lpf_pkg::KERNEL_DIM; c++) begin
					win[(ch*lpf_pkg::WIN_TAPS + r*lpf_pkg::KERNEL_DIM + c)*lpf_pkg::CHAN_W
						+: lpf_pkg::CHAN_W] = win_pix[r][c][ch*lpf_pkg::CHAN_W +: lpf_pkg::CHAN_W];
				end
			end
		end
	end

endmodule

//--- design/channel_blur.sv
`timescale 1ns/1ps

module channel_blur (
	input logic clk,
	input logic rst_n,
	input logic win_valid,
	input lpf_pkg::chan_win_t chan_win,
	input logic win_border,
	output lpf_pkg::fixed_t result
);

	lpf_pkg::wsum_t wsum;
	lpf_pkg::channel_t centre;

	// The middle tap of a row-major window
	assign centre = chan_win[(lpf_pkg::WIN_TAPS/2)*lpf_pkg::CHAN_W +: lpf_pkg::CHAN_W];

	// Weighted sum with every weight a power of two, so each tap is only shifted
	always_comb begin
		lpf_pkg::channel_t tap;
		int unsigned shamt;
		wsum = '0;
		for (int r = 0; r < lpf_pkg::KERNEL_DIM; r++) begin
			for (int c = 0; c < lpf_pkg::KERNEL_DIM; c++) begin
				tap = chan_win[(r*lpf_pkg::KERNEL_DIM + c)*lpf_pkg::CHAN_W +: lpf_pkg::CHAN_W];
				if ((r == lpf_pkg::KERNEL_DIM/2) && (c == lpf_pkg::KERNEL_DIM/2)) begin
					shamt = lpf_pkg::CENTRE_SHIFT;
				end else if ((r == lpf_pkg::KERNEL_DIM/2) || (c == lpf_pkg::KERNEL_DIM/2)) begin
					shamt = lpf_pkg::EDGE_SHIFT;
				end else begin
					shamt = lpf_pkg::CORNER_SHIFT;
				end
				wsum = wsum + (lpf_pkg::wsum_t'(tap) << shamt);
			end
		end
	end

	// Border and bypass centres skip the kernel and are only rescaled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else if (win_valid) begin
			if (win_border) begin
				result <= lpf_pkg::fixed_t'(centre) << lpf_pkg::PIX_TO_Q_SHIFT;
			end else begin
				result <= lpf_pkg::fixed_t'(wsum) << lpf_pkg::SUM_TO_Q_SHIFT;
			end
		end
	end

endmodule

//--- design/frame_out.sv
`timescale 1ns/1ps

module frame_out (
	input logic clk,
	input logic rst_n,
	input logic win_valid,
	input logic win_first,
	input logic win_last,
	input lpf_pkg::fixed_t red,
	input lpf_pkg::fixed_t green,
	input lpf_pkg::fixed_t blue,
	output logic pixel_valid_out,
	output logic soc_out,
	output logic eoc_out,
	output lpf_pkg::fixed_t pixel_out_red,
	output lpf_pkg::fixed_t pixel_out_green,
	output lpf_pkg::fixed_t pixel_out_blue
);

	// Markers delayed by the one cycle that the channel filters take
	logic valid_d;
	logic first_d;
	logic last_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_d <= 1'b0;
			first_d <= 1'b0;
			last_d <= 1'b0;
		end else begin
			valid_d <= win_valid;
			// Start and end only count on a window that is actually valid
			first_d <= win_valid && win_first;
			last_d <= win_valid && win_last;
		end
	end

	// Output register stage, markers and channel data now line up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pixel_valid_out <= 1'b0;
			soc_out <= 1'b0;
			eoc_out <= 1'b0;
		end else begin
			pixel_valid_out <= valid_d;
			soc_out <= first_d;
			eoc_out <= last_d;
		end
	end

	// The channel outputs hold their last value between pixels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pixel_out_red <= '0;
			pixel_out_green <= '0;
			pixel_out_blue <= '0;
		end else if (valid_d) begin
			pixel_out_red <= red;
			pixel_out_green <= green;
			pixel_out_blue <= blue;
		end
	end

endmodule

//--- design/lpf_top.sv
`timescale 1ns/1ps

module lpf_top (
	input logic clk,
	input logic rst_n,
	input logic blur_en,
	input logic pixel_valid,
	input logic soc_in,
	input logic eoc_in,
	input lpf_pkg::pixel_t pixel_in,
	output logic pixel_valid_out,
	output logic soc_out,
	output logic eoc_out,
	output lpf_pkg::fixed_t pixel_out_red,
	output lpf_pkg::fixed_t pixel_out_green,
	output lpf_pkg::fixed_t pixel_out_blue
);

	// Window stream from window_gen
	logic win_valid;
	lpf_pkg::window_t win;
	logic win_border;
	logic win_first;
	logic win_last;

	// One Q12.12 result per colour channel, indexed like the pixel bytes
	lpf_pkg::fixed_t chan_result [lpf_pkg::NUM_CHANNELS];

	window_gen window_gen_inst (
		.clk(clk),
		.rst_n(rst_n),
		.pixel_valid(pixel_valid),
		.soc_in(soc_in),
		.eoc_in(eoc_in),
		.blur_en(blur_en),
		.pixel_in(pixel_in),
		.win_valid(win_valid),
		.win(win),
		.win_border(win_border),
		.win_first(win_first),
		.win_last(win_last)
	);

	// The three channels run the same kernel side by side on their own slice
	for (genvar g = 0; g < lpf_pkg::NUM_CHANNELS; g++) begin : gen_chan
		channel_blur channel_blur_inst (
			.clk(clk),
			.rst_n(rst_n),
			.win_valid(win_valid),
			.chan_win(win[g*lpf_pkg::CHAN_WIN_W +: lpf_pkg::CHAN_WIN_W]),
			.win_border(win_border),
			.result(chan_result[g])
		);
	end

	frame_out frame_out_inst (
		.clk(clk),
		.rst_n(rst_n),
		.win_valid(win_valid),
		.win_first(win_first),
		.win_last(win_last),
		.red(chan_result[lpf_pkg::CH_RED]),
		.green(chan_result[lpf_pkg::CH_GREEN]),
		.blue(chan_result[lpf_pkg::CH_BLUE]),
		.pixel_valid_out(pixel_valid_out),
		.soc_out(soc_out),
		.eoc_out(eoc_out),
		.pixel_out_red(pixel_out_red),
		.pixel_out_green(pixel_out_green),
		.pixel_out_blue(pixel_out_blue)
	);

endmodule

//--- tb/lpf_checker.sv
`timescale 1ns/1ps

module lpf_checker (
	input logic clk,
	input logic rst_n,
	input logic blur_en,
	input logic pixel_valid,
	input logic soc_in,
	input lpf_pkg::pixel_t pixel_in,
	input logic pixel_valid_out,
	input logic soc_out,
	input logic eoc_out,
	input lpf_pkg::fixed_t pixel_out_red,
	input lpf_pkg::fixed_t pixel_out_green,
	input lpf_pkg::fixed_t pixel_out_blue,
	output int error_count,
	output int frame_outputs
);

	// Copy of the frame on the input side in raster order, with the mode taken on its first beat
	lpf_pkg::pixel_t image [lpf_pkg::IMAGE_DIM*lpf_pkg::IMAGE_DIM];
	logic frame_blur;
	// Open from the first input pixel until the last output pixel of the frame
	logic frame_open;
	int in_idx;
	int out_idx;
	int errs;

	// One colour byte of a stored pixel, lane 2 is red and lane 0 is blue
	function automatic int chan_at(input int r, input int c, input int lane);
		return int'(image[r*lpf_pkg::IMAGE_DIM + c][lane*8 +: 8]);
	endfunction

	// Reference value of one output channel in Q12.12
	function automatic lpf_pkg::fixed_t expect_chan(input int r, input int c, input int lane);
		int last;
		int acc;
		int weight;
		last = lpf_pkg::IMAGE_DIM - 1;
		// Bypass and the outer ring keep the raw channel, times 4096 in Q12.12
		if (!frame_blur || r == 0 || c == 0 || r == last || c == last) begin
			return lpf_pkg::fixed_t'(chan_at(r, c, lane) * 4096);
		end
		acc = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				// Centre counts 4, the four direct neighbours 2, the diagonals 1
				weight = (dr == 0 && dc == 0) ? 4 : ((dr == 0 || dc == 0) ? 2 : 1);
				acc += weight * chan_at(r + dr, c + dc, lane);
			end
		end
		// The weights add up to 16, so the mean in Q12.12 is the sum times 256
		return lpf_pkg::fixed_t'(acc * 256);
	endfunction

	task automatic compare_value(input string name, input lpf_pkg::fixed_t expected,
		input lpf_pkg::fixed_t actual);
		if (actual !== expected) begin
			errs++;
			$display("[ERROR] t=%0t %s expected 0x%06h got 0x%06h", $time, name, expected, actual);
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		int npix;
		int r;
		int c;
		npix = lpf_pkg::IMAGE_DIM * lpf_pkg::IMAGE_DIM;
		if (!rst_n) begin
			frame_blur = 1'b0;
			frame_open = 1'b0;
			in_idx = npix;
			out_idx = 0;
			errs = 0;
		end else begin
			// Output side, the outputs come in raster order of the open frame
			if (pixel_valid_out) begin
				if (!frame_open) begin
					errs++;
					$display("Output pixel at t=%0t while no frame output was pending", $time);
				end else begin
					r = out_idx / lpf_pkg::IMAGE_DIM;
					c = out_idx % lpf_pkg::IMAGE_DIM;
					compare_value("pixel_out_red", expect_chan(r, c, 2), pixel_out_red);
					compare_value("pixel_out_green", expect_chan(r, c, 1), pixel_out_green);
					compare_value("pixel_out_blue", expect_chan(r, c, 0), pixel_out_blue);
					compare_value("soc_out", lpf_pkg::fixed_t'(out_idx == 0),
						lpf_pkg::fixed_t'(soc_out));
					compare_value("eoc_out", lpf_pkg::fixed_t'(out_idx == npix - 1),
						lpf_pkg::fixed_t'(eoc_out));
					out_idx++;
					frame_open = (out_idx < npix);
				end
			end else if (soc_out || eoc_out) begin
				errs++;
				$display("Frame marker at t=%0t came without a valid output pixel", $time);
			end
			// Input side, a marked first pixel opens a new frame
			if (pixel_valid && soc_in) begin
				if (frame_open) begin
					errs++;
					$display("New frame at t=%0t started before the last one drained", $time);
				end
				frame_blur = blur_en;
				frame_open = 1'b1;
				image[0] = pixel_in;
				in_idx = 1;
				out_idx = 0;
			end else if (pixel_valid && in_idx < npix) begin
				image[in_idx] = pixel_in;
				in_idx++;
			end
		end
		error_count <= errs;
		frame_outputs <= out_idx;
	end

endmodule

//--- tb/lpf_tb.sv
`timescale 1ns/1ps

module lpf_tb;

	logic clk;
	logic rst_n;
	logic blur_en;
	logic pixel_valid;
	logic soc_in;
	logic eoc_in;
	lpf_pkg::pixel_t pixel_in;
	logic pixel_valid_out;
	logic soc_out;
	logic eoc_out;
	lpf_pkg::fixed_t pixel_out_red;
	lpf_pkg::fixed_t pixel_out_green;
	lpf_pkg::fixed_t pixel_out_blue;

	// Error counts from the checker and from the frame sequencing here
	int error_count;
	int frame_outputs;
	int own_errors;
	int tests_run;
	int tests_failed;
	logic [31:0] rng_state;
	// Set when a frame end never arrives so that no further frame is sent
	logic timed_out;

	lpf_top lpf_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.blur_en(blur_en),
		.pixel_valid(pixel_valid),
		.soc_in(soc_in),
		.eoc_in(eoc_in),
		.pixel_in(pixel_in),
		.pixel_valid_out(pixel_valid_out),
		.soc_out(soc_out),
		.eoc_out(eoc_out),
		.pixel_out_red(pixel_out_red),
		.pixel_out_green(pixel_out_green),
		.pixel_out_blue(pixel_out_blue)
	);

	lpf_checker checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.blur_en(blur_en),
		.pixel_valid(pixel_valid),
		.soc_in(soc_in),
		.pixel_in(pixel_in),
		.pixel_valid_out(pixel_valid_out),
		.soc_out(soc_out),
		.eoc_out(eoc_out),
		.pixel_out_red(pixel_out_red),
		.pixel_out_green(pixel_out_green),
		.pixel_out_blue(pixel_out_blue),
		.error_count(error_count),
		.frame_outputs(frame_outputs)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Sends one frame in raster order, with up to gap_max idle cycles before each beat
	task automatic send_frame(input logic mode, input int gap_max);
		int npix;
		int gap;
		npix = lpf_pkg::IMAGE_DIM * lpf_pkg::IMAGE_DIM;
		for (int i = 0; i < npix; i++) begin
			gap = 0;
			if (gap_max > 0) begin
				rng_state = lcg_next(rng_state);
				gap = int'(rng_state[31:24]) % (gap_max + 1);
			end
			for (int g = 0; g < gap; g++) begin
				pixel_valid <= 1'b0;
				soc_in <= 1'b0;
				eoc_in <= 1'b0;
				@(posedge clk);
			end
			// The upper bits of the LCG state are the better random ones
			rng_state = lcg_next(rng_state);
			pixel_valid <= 1'b1;
			pixel_in <= rng_state[31:8];
			soc_in <= (i == 0);
			eoc_in <= (i == npix - 1);
			blur_en <= mode;
			@(posedge clk);
		end
		pixel_valid <= 1'b0;
		soc_in <= 1'b0;
		eoc_in <= 1'b0;
	endtask

	task automatic wait_frame_end(input int limit, output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < limit) begin
			@(posedge clk);
			cycles++;
			seen = eoc_out;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		int errs_new;
		errs_new = error_count + own_errors - errs_before;
		tests_run++;
		if (errs_new == 0) begin
			$display("Test %0d %s: pass", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: fail with %0d errors", tests_run, name, errs_new);
		end
	endtask

	task automatic run_frame_test(input string name, input logic mode, input int gap_max);
		int errs_before;
		int limit;
		logic seen;
		errs_before = error_count + own_errors;
		// The flush and the pipeline finish well inside four rows after the last beat
		limit = 4 * lpf_pkg::IMAGE_DIM + 64;
		if (!timed_out) begin
			send_frame(mode, gap_max);
			wait_frame_end(limit, seen);
			if (!seen) begin
				timed_out = 1'b1;
				own_errors++;
				$display("Timeout in test %s, eoc_out did not arrive within %0d cycles", name,
					limit);
			end else begin
				// One more edge lets the checker counters take in the last output
				@(posedge clk);
				if (frame_outputs != lpf_pkg::IMAGE_DIM * lpf_pkg::IMAGE_DIM) begin
					own_errors++;
					$display("Test %s gave %0d output pixels instead of %0d", name,
						frame_outputs, lpf_pkg::IMAGE_DIM * lpf_pkg::IMAGE_DIM);
				end
			end
			report_test(name, errs_before);
		end
	endtask

	initial begin
		int errs_before;
		rst_n = 1'b0;
		blur_en = 1'b0;
		pixel_valid = 1'b0;
		soc_in = 1'b0;
		eoc_in = 1'b0;
		pixel_in = '0;
		own_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		rng_state = 32'h15779aa4;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// With no input the checker flags any output activity
		errs_before = error_count + own_errors;
		for (int i = 0; i < 24; i++) begin
			@(posedge clk);
		end
		report_test("idle_after_reset", errs_before);

		run_frame_test("bypass_back_to_back", 1'b0, 0);
		run_frame_test("blur_back_to_back", 1'b1, 0);
		run_frame_test("blur_with_gaps", 1'b1, 3);
		run_frame_test("bypass_with_gaps", 1'b0, 3);
		// Modes alternate from frame to frame and each frame uses its own first-beat mode
		for (int k = 0; k < 4; k++) begin
			run_frame_test($sformatf("alternating_%0d", k), k[0], 1);
		end
		for (int k = 0; k < 2; k++) begin
			rng_state = lcg_next(rng_state);
			run_frame_test($sformatf("random_mode_%0d", k), rng_state[31], 2);
		end

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			error_count + own_errors);
		if (!timed_out && tests_failed == 0 && error_count + own_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
common/lpf_pkg.sv
window/line_buffer.sv
window/window_gen.sv
design/channel_blur.sv
design/frame_out.sv
design/lpf_top.sv
tb/lpf_checker.sv
tb/lpf_tb.sv

//--- run.sh
#!/bin/sh
# Builds lpf_tb with Verilator and runs it, the log decides pass or fail
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f vlog.f --top-module lpf_tb --Mdir "$BUILD_DIR" -o lpf_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

"./$BUILD_DIR/lpf_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1
